// File: hw/gat_macros.svh
`ifndef GAT_MACROS_SVH
`define GAT_MACROS_SVH

// index entries, one per node
`define TOTAL_NODES 24

// words in one output feature vector
`define NUM_FEATURE_OUT 4

// groups in the index memory
`define NUM_SUBGRAPHS 6

// raw feature word from the aggregator
`define NEW_FEATURE_WIDTH 32

// value bits kept per H entry
`define DATA_WIDTH 8

// whole vectors held ahead of the writer
`define FEAT_FIFO_DEPTH 4

`endif

// File: hw/gat_pkg.sv
`include "gat_macros.svh"

package gat_pkg;

  // one feature word as produced upstream
  typedef logic [`NEW_FEATURE_WIDTH-1:0] feat_word_t;
  // full vector, word 0 in the low bits
  typedef feat_word_t [`NUM_FEATURE_OUT-1:0] feat_vec_t;

  typedef logic [$clog2(`TOTAL_NODES)-1:0] node_idx_t;
  // index memory has one entry per node
  typedef logic [$clog2(`TOTAL_NODES)-1:0] idx_addr_t;
  // sog on top, node index, eog at bit 0
  typedef logic [$bits(node_idx_t)+1:0] idx_word_t;

  // word number inside a vector, doubles as H column
  typedef logic [$clog2(`NUM_FEATURE_OUT)-1:0] feat_cnt_t;
  typedef logic [$clog2(`TOTAL_NODES*`NUM_FEATURE_OUT)-1:0] h_addr_t;
  // truncated value above its column index
  typedef logic [`DATA_WIDTH+$bits(feat_cnt_t)-1:0] h_entry_t;

  // write-back FSM
  typedef enum logic [1:0] {
    idle,
    wait_feat,
    write,
    done
  } wr_state_t;

endpackage

// File: hw/node_entry_if.sv
`timescale 1ns/10ps

interface node_entry_if;
  import gat_pkg::*;

  // entry on offer, held until next
  logic      entry_vld;
  node_idx_t node_idx;
  // closes the current group
  logic      eog;
  // index address TOTAL_NODES-1
  logic      last_entry;
  // one-cycle retire pulse from the writer
  logic      next;

  modport reader (
    output entry_vld, node_idx, eog, last_entry,
    input  next
  );

  modport writer (
    input  entry_vld, node_idx, eog, last_entry,
    output next
  );

endinterface

// File: hw/feat_fifo.sv
`timescale 1ns/10ps
`include "gat_macros.svh"

module feat_fifo (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               wr,
  input  gat_pkg::feat_vec_t din,
  input  logic               rd,
  output gat_pkg::feat_vec_t dout,
  output logic               empty,
  output logic               full
);
  import gat_pkg::*;

  localparam int ptr_w = $clog2(`FEAT_FIFO_DEPTH);
  localparam logic [ptr_w-1:0] ptr_last = ptr_w'(`FEAT_FIFO_DEPTH - 1);

  feat_vec_t        mem [`FEAT_FIFO_DEPTH];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w:0]   count;
  logic             do_wr;
  logic             do_rd;

  // drop illegal requests, the assertions below flag them
  assign do_wr = wr && !full;
  assign do_rd = rd && !empty;

  // vector storage
  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == ptr_last) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == ptr_last) ? '0 : rd_ptr + 1'b1;
      end
      // occupancy only moves on a lone push or pop
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // head is visible without a read cycle
  assign dout  = mem[rd_ptr];
  assign empty = (count == '0);
  assign full  = (count == (ptr_w + 1)'(`FEAT_FIFO_DEPTH));

  // aggregator must respect the ready level
  assert property (@(posedge clk) disable iff (!rst_n) wr |-> !full)
    else $error("feat_fifo: push while full");

  // writer only pops a vector it has used
  assert property (@(posedge clk) disable iff (!rst_n) rd |-> !empty)
    else $error("feat_fifo: pop while empty");

endmodule

// File: hw/subgraph_idx_reader.sv
`timescale 1ns/10ps
`include "gat_macros.svh"

module subgraph_idx_reader (
  input  logic               clk,
  input  logic               rst_n,
  output gat_pkg::idx_addr_t bram_addr,
  input  gat_pkg::idx_word_t bram_dout,
  node_entry_if.reader       entry
);
  import gat_pkg::*;

  localparam idx_addr_t last_addr = idx_addr_t'(`TOTAL_NODES - 1);

  idx_addr_t addr_q;
  logic      start_q;
  logic      fetch_pend;
  idx_word_t word_q;
  logic      sog;
  logic      after_eog;

  // address runs one entry ahead
  // so memory output is settled by the time next arrives
  assign bram_addr = addr_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      start_q          <= 1'b1;
      fetch_pend       <= 1'b0;
      addr_q           <= '0;
      entry.entry_vld  <= 1'b0;
      entry.last_entry <= 1'b0;
      // first entry must open a group
      after_eog        <= 1'b1;
    end else begin
      start_q    <= 1'b0;
      // one fetch after reset and per retired entry, none past the last
      fetch_pend <= start_q || (entry.next && !entry.last_entry);
      if (fetch_pend) begin
        entry.entry_vld  <= 1'b1;
        entry.last_entry <= (addr_q == last_addr);
        if (addr_q != last_addr) begin
          addr_q <= addr_q + 1'b1;
        end
      end else if (entry.next) begin
        entry.entry_vld <= 1'b0;
      end
      if (entry.next) begin
        after_eog <= entry.eog;
      end
    end
  end

  // returned index word, held for the whole entry
  always_ff @(posedge clk) begin
    if (fetch_pend) begin
      word_q <= bram_dout;
    end
  end

  assign {sog, entry.node_idx, entry.eog} = word_q;

  // group boundaries in the index memory must pair up
  assert property (@(posedge clk) disable iff (!rst_n)
    $rose(entry.entry_vld) && after_eog |-> sog)
    else $error("subgraph_idx_reader: entry after eog lacks sog");

endmodule

// File: hw/h_data_writer.sv
`timescale 1ns/10ps
`include "gat_macros.svh"

module h_data_writer (
  input  logic               clk,
  input  logic               rst_n,
  node_entry_if.writer       entry,
  input  gat_pkg::feat_vec_t feat_dout,
  input  logic               feat_empty,
  output logic               feat_pop,
  output gat_pkg::h_addr_t   h_addr,
  output gat_pkg::h_entry_t  h_din,
  output logic               h_en,
  output logic               h_we,
  output logic               gat_ready
);
  import gat_pkg::*;

  localparam feat_cnt_t cnt_last = feat_cnt_t'(`NUM_FEATURE_OUT - 1);

  wr_state_t  state;
  wr_state_t  state_nxt;
  feat_cnt_t  cnt;
  feat_word_t cur_word;
  h_addr_t    base_addr;
  logic       last_word;

  // final word of the current entry
  assign last_word = (state == write) && (cnt == cnt_last);

  always_comb begin
    state_nxt = state;
    case (state)
      idle: begin
        // entry seen, write starts next cycle if a vector is queued
        if (entry.entry_vld) begin
          state_nxt = feat_empty ? wait_feat : write;
        end
      end
      wait_feat: begin
        if (!feat_empty) begin
          state_nxt = write;
        end
      end
      write: begin
        if (last_word) begin
          state_nxt = entry.last_entry ? done : idle;
        end
      end
      // held until reset
      done: state_nxt = done;
      default: state_nxt = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= idle;
      cnt   <= '0;
    end else begin
      state <= state_nxt;
      if (state == write) begin
        cnt <= last_word ? '0 : cnt + 1'b1;
      end
    end
  end

  // row base for this node
  assign base_addr = h_addr_t'(entry.node_idx) * h_addr_t'(`NUM_FEATURE_OUT);
  assign h_addr    = base_addr + h_addr_t'(cnt);

  // low value bits with the word number as column
  assign cur_word = feat_dout[cnt];
  assign h_din    = {cur_word[`DATA_WIDTH-1:0], cnt};

  // enable and write strobe pulse together
  assign h_en = (state == write);
  assign h_we = (state == write);

  // retire entry on its last word, pop the vector at group end
  assign entry.next = last_word;
  assign feat_pop   = last_word && entry.eog;
  assign gat_ready  = (state == done);

  // writes only with a queued vector and an entry on offer
  assert property (@(posedge clk) disable iff (!rst_n)
    h_en |-> !feat_empty && entry.entry_vld)
    else $error("h_data_writer: H write without vector or entry");

  // reader has to withdraw a retired entry
  assert property (@(posedge clk) disable iff (!rst_n)
    entry.next |=> !entry.entry_vld)
    else $error("h_data_writer: entry still valid after next");

endmodule

// File: hw/subgraph_handler.sv
`timescale 1ns/10ps

module subgraph_handler (
  input  logic               clk,
  input  logic               rst_n,

  // new feature vectors from the aggregator
  input  logic               subgraph_vld_i,
  input  gat_pkg::feat_vec_t new_feat,
  output logic               subgraph_rdy_o,

  // subgraph index memory, one cycle read latency
  output gat_pkg::idx_addr_t subgraph_bram_addrb,
  input  gat_pkg::idx_word_t subgraph_bram_dout,

  // H data memory write port
  output gat_pkg::h_addr_t   h_data_bram_addra,
  output gat_pkg::h_entry_t  h_data_bram_din,
  output logic               h_data_bram_ena,
  output logic               h_data_bram_wea,

  output logic               gat_ready
);
  import gat_pkg::*;

  // head of the vector queue
  feat_vec_t feat_dout;
  logic      feat_empty;
  logic      feat_full;
  logic      feat_pop;

  // current index entry, reader to writer
  node_entry_if entry_if ();

  feat_fifo u_feat_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (subgraph_vld_i),
    .din   (new_feat),
    .rd    (feat_pop),
    .dout  (feat_dout),
    .empty (feat_empty),
    .full  (feat_full)
  );

  // space left for another vector
  assign subgraph_rdy_o = !feat_full;

  subgraph_idx_reader u_idx_reader (
    .clk       (clk),
    .rst_n     (rst_n),
    .bram_addr (subgraph_bram_addrb),
    .bram_dout (subgraph_bram_dout),
    .entry     (entry_if.reader)
  );

  h_data_writer u_h_writer (
    .clk        (clk),
    .rst_n      (rst_n),
    .entry      (entry_if.writer),
    .feat_dout  (feat_dout),
    .feat_empty (feat_empty),
    .feat_pop   (feat_pop),
    .h_addr     (h_data_bram_addra),
    .h_din      (h_data_bram_din),
    .h_en       (h_data_bram_ena),
    .h_we       (h_data_bram_wea),
    .gat_ready  (gat_ready)
  );

endmodule

// File: sim/tb_subgraph_handler.sv
`timescale 1ns/10ps
`include "gat_macros.svh"

module tb_subgraph_handler;
  import gat_pkg::*;

  localparam int n_nodes  = `TOTAL_NODES;
  localparam int n_words  = `NUM_FEATURE_OUT;
  localparam int n_groups = `NUM_SUBGRAPHS;
  localparam int depth    = `FEAT_FIFO_DEPTH;
  localparam int n_writes = n_nodes * n_words;
  // 24 entries of 4 words, stalls and feature gaps fit well inside this
  localparam int max_cycles = 2000;

  logic      clk = 1'b0;
  logic      rst_n;
  logic      subgraph_vld_i;
  feat_vec_t new_feat;
  logic      subgraph_rdy_o;
  idx_addr_t subgraph_bram_addrb;
  idx_word_t subgraph_bram_dout;
  h_addr_t   h_data_bram_addra;
  h_entry_t  h_data_bram_din;
  logic      h_data_bram_ena;
  logic      h_data_bram_wea;
  logic      gat_ready;

  integer    seed = 32'h53a463b8;
  idx_word_t idx_mem [n_nodes];
  // group of each node, and whether it closes that group
  int        node_group [n_nodes];
  logic      group_last [n_nodes];
  feat_vec_t feats [n_groups];
  bit        written [n_writes];
  // vectors pushed, vectors queued in the FIFO, H writes seen
  int        push_cnt = 0;
  int        occ = 0;
  int        write_cnt = 0;
  int        cycles = 0;
  int        mismatch_errs = 0;
  int        other_errs = 0;
  bit        saw_full = 1'b0;

  subgraph_handler u_dut (
    .clk                 (clk),
    .rst_n               (rst_n),
    .subgraph_vld_i      (subgraph_vld_i),
    .new_feat            (new_feat),
    .subgraph_rdy_o      (subgraph_rdy_o),
    .subgraph_bram_addrb (subgraph_bram_addrb),
    .subgraph_bram_dout  (subgraph_bram_dout),
    .h_data_bram_addra   (h_data_bram_addra),
    .h_data_bram_din     (h_data_bram_din),
    .h_data_bram_ena     (h_data_bram_ena),
    .h_data_bram_wea     (h_data_bram_wea),
    .gat_ready           (gat_ready)
  );

  always #50 clk = ~clk;

  // index memory, one cycle read latency
  always @(posedge clk) begin
    subgraph_bram_dout <= idx_mem[subgraph_bram_addrb];
  end

  // expected H word: node's group picks the vector, column picks the word
  function automatic h_entry_t expected_entry(input h_addr_t addr);
    int         node;
    int         col;
    feat_word_t word;
    node = int'(addr) / n_words;
    col  = int'(addr) % n_words;
    word = feats[node_group[node]][col];
    return {word[`DATA_WIDTH-1:0], feat_cnt_t'(col)};
  endfunction

  task automatic report_counts;
    $display("errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
  endtask

  // H memory model and checker, sampled mid-cycle
  always @(negedge clk) begin : compare
    int   node;
    int   col;
    logic pop;
    pop = 1'b0;
    if (rst_n) begin
      assert (subgraph_rdy_o == (occ != depth)) else begin
        mismatch_errs++;
        $display("Mismatch at time %0t: subgraph_rdy_o=%0b with %0d vectors queued",
                 $time, subgraph_rdy_o, occ);
      end
      if (!subgraph_rdy_o) begin
        saw_full = 1'b1;
      end
      assert (gat_ready == (write_cnt == n_writes)) else begin
        mismatch_errs++;
        $display("Mismatch at time %0t: gat_ready=%0b after %0d writes",
                 $time, gat_ready, write_cnt);
      end
      // enable and write strobe always move together
      assert (h_data_bram_wea == h_data_bram_ena) else begin
        mismatch_errs++;
        $display("Mismatch at time %0t: wea=%0b with ena=%0b",
                 $time, h_data_bram_wea, h_data_bram_ena);
      end
      if (h_data_bram_ena) begin
        if (int'(h_data_bram_addra) >= n_writes) begin
          other_errs++;
          $display("H write to out-of-range address %0d at time %0t",
                   h_data_bram_addra, $time);
        end else begin
          node = int'(h_data_bram_addra) / n_words;
          col  = int'(h_data_bram_addra) % n_words;
          assert (!written[h_data_bram_addra]) else begin
            other_errs++;
            $display("H address %0d written twice, at time %0t", h_data_bram_addra, $time);
          end
          written[h_data_bram_addra] = 1'b1;
          // a group may only be written once its vector has gone in
          assert (node_group[node] < push_cnt) else begin
            other_errs++;
            $display("node %0d written before vector %0d was sent, at time %0t",
                     node, node_group[node], $time);
          end
          assert (h_data_bram_din == expected_entry(h_data_bram_addra)) else begin
            mismatch_errs++;
            $display("Mismatch at time %0t: addr %0d got %h expected %h", $time,
                     h_data_bram_addra, h_data_bram_din, expected_entry(h_data_bram_addra));
          end
          // last word of a group end frees a FIFO slot
          pop = (col == n_words - 1) && group_last[node];
        end
        write_cnt++;
      end
      occ = occ + int'(subgraph_vld_i) - int'(pop);
      if (subgraph_vld_i) begin
        push_cnt++;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      other_errs++;
      $display("timeout: gat_ready did not rise within %0d cycles", max_cycles);
      report_counts();
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial begin : stimulus
    int perm [n_nodes];
    int sizes [n_groups];
    int j;
    int tmp;
    int g;
    int e;
    int node;
    int v;
    int gap;
    rst_n              = 1'b0;
    subgraph_vld_i     = 1'b0;
    new_feat           = '0;
    subgraph_bram_dout = '0;

    // shuffled node order
    for (int i = 0; i < n_nodes; i++) begin
      perm[i] = i;
    end
    for (int i = n_nodes - 1; i > 0; i--) begin
      j       = {$random(seed)} % (i + 1);
      tmp     = perm[i];
      perm[i] = perm[j];
      perm[j] = tmp;
    end
    // every group gets one node, the rest land anywhere
    for (int i = 0; i < n_groups; i++) begin
      sizes[i] = 1;
    end
    for (int i = 0; i < n_nodes - n_groups; i++) begin
      g = {$random(seed)} % n_groups;
      sizes[g]++;
    end
    e = 0;
    for (int gi = 0; gi < n_groups; gi++) begin
      for (int k = 0; k < sizes[gi]; k++) begin
        node             = perm[e];
        node_group[node] = gi;
        group_last[node] = (k == sizes[gi] - 1);
        idx_mem[e]       = {k == 0, node_idx_t'(node), k == sizes[gi] - 1};
        e++;
      end
      for (int w = 0; w < n_words; w++) begin
        feats[gi][w] = $random(seed);
      end
    end

    repeat (9) @(posedge clk);
    @(negedge clk);
    assert (!h_data_bram_ena && !gat_ready && subgraph_rdy_o) else begin
      other_errs++;
      $display("outputs not at their reset values at time %0t", $time);
    end
    @(posedge clk);
    rst_n <= 1'b1;

    // withhold vectors, writer has to stall on the first entry
    repeat (30) @(posedge clk);

    // first vectors back to back to fill the FIFO, then random gaps
    v   = 0;
    gap = 0;
    while (v < n_groups) begin
      @(posedge clk);
      if (gap > 0) begin
        subgraph_vld_i <= 1'b0;
        gap = gap - 1;
      end else if (occ < depth) begin
        subgraph_vld_i <= 1'b1;
        new_feat       <= feats[v];
        v = v + 1;
        gap = (v < depth) ? 0 : {$random(seed)} % 8;
      end else begin
        subgraph_vld_i <= 1'b0;
      end
    end
    @(posedge clk);
    subgraph_vld_i <= 1'b0;

    while (gat_ready !== 1'b1) begin
      @(posedge clk);
    end
    // quiet tail, no stray writes after completion
    repeat (5) @(posedge clk);
    assert (write_cnt == n_writes) else begin
      other_errs++;
      $display("expected %0d H writes, saw %0d", n_writes, write_cnt);
    end
    assert (saw_full) else begin
      other_errs++;
      $display("subgraph_rdy_o never dropped during the burst");
    end
    report_counts();
    if (mismatch_errs + other_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: sim.f
+incdir+hw
hw/gat_pkg.sv
hw/node_entry_if.sv
hw/feat_fifo.sv
hw/subgraph_idx_reader.sv
hw/h_data_writer.sv
hw/subgraph_handler.sv
sim/tb_subgraph_handler.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_subgraph_handler
FILELIST = sim.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
FAIL_MSG = Simulation finished: FAIL
PASS_MSG = Simulation finished: PASS
SRCS     = $(shell grep -v '^+' $(FILELIST)) hw/gat_macros.svh

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "no result line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
